//--- filelist.f
+incdir+.
core_mem_pkg.sv
axi_lite_pkg.sv
limp_arbiter.sv
access_decode.sv
read_extract.sv
axi_manager_fsm.sv
mem_port_top.sv
tb_mem_port.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the memory port testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
        --top-module tb_mem_port -o tb_mem_port > build.log 2>&1 \
    && ./obj_dir/tb_mem_port > sim.log 2>&1 \
    || { echo "Build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^Testbench passed$" sim.log && echo "Result: PASS" \
    || { echo "Result: FAIL"; exit 1; }

//--- tb_mem_port.sv
// Memory port testbench
// Random requestor traffic against an AXI4-Lite memory model and a shadow copy
`timescale 1ns/1ps
`include "mem_defs.svh"

module tb_mem_port;

    import core_mem_pkg::*;
    import axi_lite_pkg::*;

    localparam int NREQ    = `MEM_NUM_REQ;
    localparam int NUM_OPS = 80;    // Requests per requestor
    localparam int TIMEOUT = 2000;  // Cycles a requestor may wait for ready
    localparam int DRAIN_LIMIT = NUM_OPS * (TIMEOUT + 12);  // Whole run per requestor
    localparam logic [`MEM_AXI_ID_W-1:0] AXI_ID = (`MEM_AXI_ID_W)'(`MEM_AXI_ID);

    logic                 i_clk;
    logic                 i_rst_n;
    logic [NREQ-1:0]      req_valid;
    limp_req_t [NREQ-1:0] req;
    logic [NREQ-1:0]      req_ready;
    word_t                rdata;
    logic                 arvalid, arready, rvalid, rready;
    logic                 awvalid, awready, wvalid, wready, bvalid, bready;
    axi_ar_t              ar;
    axi_r_t               r;
    axi_aw_t              aw;
    axi_w_t               w;
    axi_b_t               b;

    integer seed     = 78;
    int     errors   = 0;
    int     finished = 0;  // Requestors that ran all their operations

    word_t mem [64];     // Subordinate storage
    word_t shadow [64];  // Expected contents, updated when a write completes

    // Subordinate state, stall counters count down to a ready or a response
    int         ar_cnt, aw_cnt, w_cnt, rd_cnt, b_cnt;
    logic       rd_pend, aw_done, w_done, b_pend;
    word_t      rd_data, wr_data;
    paddr_t     wr_addr;
    logic [3:0] wr_strb;

    logic busy, rst_q, ar_pend, aw_pend, w_pend;  // Monitor state
    int   grant_idx;

    mem_port_top u_mem_port_top (.*);

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    function automatic int rand_upto(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp)
            else begin
                errors++;
                $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            end
    endtask

    // Byte lanes touched by a store
    function automatic logic [3:0] lane_mask(input limp_req_t q);
        logic [3:0] m;
        for (int k = 0; k < 4; k++) begin
            case (q.size)
                SIZE_BYTE:     m[k] = (2'(k) == q.addr[1:0]);
                SIZE_HALFWORD: m[k] = ((k >= 2) == q.addr[1]);
                default:       m[k] = 1'b1;
            endcase
        end
        return m;
    endfunction

    // Lane k carries store byte k modulo the access width
    function automatic word_t lane_data(input limp_req_t q);
        word_t d;
        int    nb;
        nb = (q.size == SIZE_BYTE) ? 1 : (q.size == SIZE_HALFWORD) ? 2 : 4;
        for (int k = 0; k < 4; k++) begin
            d[8*k +: 8] = q.wdata[8*(k % nb) +: 8];
        end
        return d;
    endfunction

    function automatic word_t read_lane(input word_t wd, input limp_req_t q);
        word_t sh;
        sh = wd >> {q.addr[1:0], 3'b000};
        case (q.size)
            SIZE_BYTE:     return {24'h0, sh[7:0]};
            SIZE_HALFWORD: return {16'h0, sh[15:0]};
            default:       return wd;
        endcase
    endfunction

    function automatic int lowest_valid();
        for (int i = 0; i < NREQ; i++) begin
            if (req_valid[i]) return i;
        end
        return 0;
    endfunction

    task automatic apply_write(input limp_req_t q);
        logic [3:0] m;
        word_t      d;
        m = lane_mask(q);
        d = lane_data(q);
        for (int k = 0; k < 4; k++) begin
            if (m[k]) shadow[q.addr[7:2]][8*k +: 8] = d[8*k +: 8];
        end
    endtask

    // One requestor, holds each request until its ready pulse
    task automatic run_requestor(input int idx);
        limp_req_t q;
        int        cycles;
        for (int n = 0; n < NUM_OPS; n++) begin
            repeat (2 + rand_upto(8)) @(negedge i_clk);  // Idle gap, valid low
            q.wen_nren = (rand_upto(2) == 1);
            q.size     = size_e'(rand_upto(3));
            q.addr     = {26'h0, 4'(rand_upto(16)), 2'b00};  // 16 words so requestors collide
            if (q.size == SIZE_BYTE) q.addr[1:0] = 2'(rand_upto(4));
            if (q.size == SIZE_HALFWORD) q.addr[1] = (rand_upto(2) == 1);
            q.wdata        = $random(seed);
            req[idx]       = q;
            req_valid[idx] = 1'b1;
            cycles = 0;
            do begin
                @(posedge i_clk);
                cycles++;
            end while (!req_ready[idx] && cycles < TIMEOUT);
            assert (req_ready[idx])
                else begin
                    errors++;
                    $display("Requestor %0d saw no ready within %0d cycles", idx, TIMEOUT);
                end
            if (!req_ready[idx]) return;
            if (q.wen_nren) apply_write(q);
            else compare_word($sformatf("rdata req%0d", idx), rdata,
                              read_lane(shadow[q.addr[7:2]], q));
            @(negedge i_clk);
            req_valid[idx] = 1'b0;
        end
    endtask

    // Subordinate bookkeeping on the rising edge
    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            {ar_cnt, aw_cnt, w_cnt, rd_cnt, b_cnt} = '0;
            {rd_pend, aw_done, w_done, b_pend} = '0;
        end else begin
            if (rvalid && rready) rd_pend = 1'b0;
            else if (rd_pend && rd_cnt > 0) rd_cnt--;
            if (arvalid && arready) begin
                rd_pend = 1'b1;
                rd_data = mem[ar.addr[7:2]];
                rd_cnt  = rand_upto(4);
                ar_cnt  = rand_upto(4);
            end else if (ar_cnt > 0) ar_cnt--;
            if (awvalid && awready) begin
                aw_done = 1'b1;
                wr_addr = aw.addr;
                aw_cnt  = rand_upto(4);
            end else if (aw_cnt > 0) aw_cnt--;
            if (wvalid && wready) begin
                w_done  = 1'b1;
                wr_data = w.data;
                wr_strb = w.strb;
                w_cnt   = rand_upto(4);
            end else if (w_cnt > 0) w_cnt--;
            if (bvalid && bready) b_pend = 1'b0;
            else if (b_pend && b_cnt > 0) b_cnt--;
            if (aw_done && w_done) begin  // Both halves in, commit and queue B
                for (int k = 0; k < 4; k++) begin
                    if (wr_strb[k]) mem[wr_addr[7:2]][8*k +: 8] = wr_data[8*k +: 8];
                end
                {aw_done, w_done} = 2'b00;
                b_pend = 1'b1;
                b_cnt  = rand_upto(4);
            end
        end
    end

    always @(negedge i_clk) begin
        arready = (ar_cnt == 0) && !rd_pend;
        rvalid  = rd_pend && (rd_cnt == 0);
        r       = '{data: rd_data, id: AXI_ID, resp: OKAY};
        awready = (aw_cnt == 0) && !aw_done;
        wready  = (w_cnt == 0) && !w_done;
        bvalid  = b_pend && (b_cnt == 0);
        b       = '{id: AXI_ID, resp: OKAY};
    end

    // Bus and arbitration monitor
    always @(posedge i_clk) begin
        if (!i_rst_n || rst_q) begin
            compare_word("arvalid/awvalid/wvalid/rready/req_ready",
                         32'({arvalid, awvalid, wvalid, rready, req_ready}), 32'h0);
        end
        if (!i_rst_n) begin
            {busy, ar_pend, aw_pend, w_pend} = '0;
            grant_idx = 0;
        end else begin
            if (ar_pend) compare_word("arvalid held", 32'(arvalid), 32'h1);
            if (aw_pend) compare_word("awvalid held", 32'(awvalid), 32'h1);
            if (w_pend) compare_word("wvalid held", 32'(wvalid), 32'h1);
            if (!busy && (arvalid || awvalid)) begin  // New transfer, check the winner
                grant_idx = lowest_valid();
                compare_word("first ar/aw addr", arvalid ? ar.addr : aw.addr,
                             {req[grant_idx].addr[31:2], 2'b00});
            end
            if (arvalid) begin
                compare_word("ar.addr[1:0]", 32'(ar.addr[1:0]), 32'h0);
                compare_word("ar.id", 32'(ar.id), 32'(AXI_ID));
            end
            if (awvalid) begin
                compare_word("aw.addr[1:0]", 32'(aw.addr[1:0]), 32'h0);
                compare_word("aw.id", 32'(aw.id), 32'(AXI_ID));
            end
            compare_word("bready", 32'(bready), 32'h1);
            if (wvalid && wready) begin
                compare_word("w.strb", 32'(w.strb), 32'(lane_mask(req[grant_idx])));
                compare_word("w.data", w.data, lane_data(req[grant_idx]));
            end
            if (|req_ready) compare_word("req_ready", 32'(req_ready), 32'(1) << grant_idx);
            busy    = (|req_ready) ? 1'b0 : (busy || arvalid || awvalid);
            ar_pend = arvalid && !arready;
            aw_pend = awvalid && !awready;
            w_pend  = wvalid && !wready;
        end
        rst_q = !i_rst_n;
    end

    initial begin
        int drain_cycles;
        i_rst_n   = 1'b0;
        req_valid = '0;
        req       = '0;
        {arready, rvalid, awready, wready, bvalid} = '0;
        r = '0;
        b = '0;
        for (int i = 0; i < 64; i++) begin
            mem[i]    = 32'hc3a5_0000 + 32'(i) * 32'h0004_1021;
            shadow[i] = mem[i];
        end
        repeat (8) @(negedge i_clk);
        i_rst_n = 1'b1;
        for (int i = 0; i < NREQ; i++) begin
            automatic int idx = i;
            fork
                begin
                    run_requestor(idx);
                    finished++;
                end
            join_none
        end
        drain_cycles = 0;
        while (finished < NREQ && drain_cycles < DRAIN_LIMIT) begin
            @(negedge i_clk);
            drain_cycles++;
        end
        repeat (4) @(negedge i_clk);
        if (finished < NREQ) begin
            errors++;
            $display("Requestors did not finish within %0d cycles", DRAIN_LIMIT);
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- mem_port_top.sv
// Core memory port
// Arbitrates requestors onto one AXI4-Lite manager, one transfer at a time
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_port_top #(
    parameter int NUM_REQUESTORS = `MEM_NUM_REQ,
    parameter int AXI_ID         = `MEM_AXI_ID
) (
    input  logic                                        i_clk,
    input  logic                                        i_rst_n,
    input  logic [NUM_REQUESTORS-1:0]                   req_valid,
    input  core_mem_pkg::limp_req_t [NUM_REQUESTORS-1:0] req,
    output logic [NUM_REQUESTORS-1:0]                   req_ready,
    output core_mem_pkg::word_t                         rdata,     // Shared by all requestors
    output logic                                        arvalid,
    input  logic                                        arready,
    output axi_lite_pkg::axi_ar_t                       ar,
    input  logic                                        rvalid,
    output logic                                        rready,
    input  axi_lite_pkg::axi_r_t                        r,
    output logic                                        awvalid,
    input  logic                                        awready,
    output axi_lite_pkg::axi_aw_t                       aw,
    output logic                                        wvalid,
    input  logic                                        wready,
    output axi_lite_pkg::axi_w_t                        w,
    input  logic                                        bvalid,
    output logic                                        bready,
    input  axi_lite_pkg::axi_b_t                        b
);

    import core_mem_pkg::*;

    logic      sel_valid;
    logic      done;
    limp_req_t sel_req;  // Granted request
    access_t   acc;

    limp_arbiter #(
        .NUM_REQUESTORS(NUM_REQUESTORS)
    ) u_limp_arbiter (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .done      (done),
        .sel_valid (sel_valid),
        .sel_req   (sel_req)
    );

    access_decode u_access_decode (
        .sel_req (sel_req),
        .acc     (acc)
    );

    axi_manager_fsm #(
        .AXI_ID(AXI_ID)
    ) u_axi_manager_fsm (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .sel_valid (sel_valid),
        .acc       (acc),
        .done      (done),
        .arvalid   (arvalid),
        .arready   (arready),
        .ar        (ar),
        .rvalid    (rvalid),
        .rready    (rready),
        .r         (r),
        .awvalid   (awvalid),
        .awready   (awready),
        .aw        (aw),
        .wvalid    (wvalid),
        .wready    (wready),
        .w         (w),
        .bvalid    (bvalid),
        .bready    (bready),
        .b         (b)
    );

    // Lane select uses the unaligned request, not the bus address
    read_extract u_read_extract (
        .rdata_bus (r.data),
        .size      (sel_req.size),
        .addr_lo   (sel_req.addr[1:0]),
        .rdata     (rdata)
    );

endmodule

//--- axi_manager_fsm.sv
// AXI4-Lite manager
// Mealy FSM that runs one single-beat read or write per request
`timescale 1ns/1ps
`include "mem_defs.svh"

module axi_manager_fsm #(
    parameter int AXI_ID = `MEM_AXI_ID
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  sel_valid,
    input  core_mem_pkg::access_t acc,
    output logic                  done,     // Pulses with the final handshake
    output logic                  arvalid,
    input  logic                  arready,
    output axi_lite_pkg::axi_ar_t ar,
    input  logic                  rvalid,
    output logic                  rready,
    input  axi_lite_pkg::axi_r_t  r,
    output logic                  awvalid,
    input  logic                  awready,
    output axi_lite_pkg::axi_aw_t aw,
    output logic                  wvalid,
    input  logic                  wready,
    output axi_lite_pkg::axi_w_t  w,
    input  logic                  bvalid,
    output logic                  bready,
    input  axi_lite_pkg::axi_b_t  b
);

    typedef enum logic [2:0] {
        IDLE,
        SEND_RADDR,  // R seen, AR still pending
        GET_RDATA,   // AR accepted, waiting on R
        SEND_WADDR,  // W accepted, AW pending
        SEND_WDATA,  // AW accepted, W pending
        GET_BRESP
    } state_e;

    state_e state;
    state_e next_state;

    logic [`MEM_AXI_ID_W-1:0] id;
    logic ar_hs;
    logic r_hs;
    logic aw_hs;
    logic w_hs;
    logic b_hs;

    assign id    = (`MEM_AXI_ID_W)'(AXI_ID);
    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;
    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign b_hs  = bvalid && bready;

    // Response arrives at least a cycle after AW/W, so B is always accepted
    assign bready = 1'b1;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;  // Hold under back-pressure
        case (state)
            IDLE: begin
                if (sel_valid && acc.wen_nren) begin
                    if (aw_hs && w_hs) begin
                        next_state = GET_BRESP;
                    end else if (aw_hs) begin
                        next_state = SEND_WDATA;
                    end else if (w_hs) begin
                        next_state = SEND_WADDR;
                    end
                end else if (sel_valid) begin
                    if (ar_hs && !r_hs) begin
                        next_state = GET_RDATA;
                    end else if (r_hs && !ar_hs) begin
                        next_state = SEND_RADDR;  // Only with a non-compliant subordinate
                    end
                end
            end
            SEND_RADDR: if (ar_hs) next_state = IDLE;
            GET_RDATA:  if (r_hs) next_state = IDLE;
            SEND_WADDR: if (aw_hs) next_state = GET_BRESP;
            SEND_WDATA: if (w_hs) next_state = GET_BRESP;
            GET_BRESP:  if (b_hs) next_state = IDLE;
            default:    next_state = IDLE;
        endcase
    end

    // Handshake outputs, done uses the raw readys to avoid a loop through *_hs
    always_comb begin
        arvalid = 1'b0;
        rready  = 1'b0;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        done    = 1'b0;
        case (state)
            IDLE: begin
                if (sel_valid && acc.wen_nren) begin
                    awvalid = 1'b1;  // Both write channels together
                    wvalid  = 1'b1;
                end else if (sel_valid) begin
                    arvalid = 1'b1;
                    rready  = 1'b1;
                    done    = arready && rvalid;  // Zero-wait read
                end
            end
            SEND_RADDR: begin
                arvalid = 1'b1;
                done    = arready;
            end
            GET_RDATA: begin
                rready = 1'b1;
                done   = rvalid;
            end
            SEND_WADDR: awvalid = 1'b1;
            SEND_WDATA: wvalid = 1'b1;
            GET_BRESP:  done = bvalid;
            default:    done = 1'b0;
        endcase
    end

    // Payloads follow the decoded access, held stable by the arbiter lock
    always_comb begin
        ar.addr = acc.addr;
        ar.id   = id;
        aw.addr = acc.addr;
        aw.id   = id;
        w.data  = acc.wdata;
        w.strb  = acc.wstrb;
    end

    a_ar_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("axi_manager_fsm: AR dropped or changed before handshake");

    a_aw_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("axi_manager_fsm: AW dropped or changed before handshake");

    a_w_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        wvalid && !wready |=> wvalid && $stable(w))
        else $error("axi_manager_fsm: W dropped or changed before handshake");

    // Subordinate must echo our single ID
    a_resp_id: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (!r_hs || r.id == id) && (!b_hs || b.id == id))
        else $error("axi_manager_fsm: response ID mismatch r %0d b %0d", r.id, b.id);

endmodule

//--- read_extract.sv
// Read lane extract
// Picks the addressed byte or halfword of the bus word and zero-extends it
`timescale 1ns/1ps

module read_extract (
    input  core_mem_pkg::word_t rdata_bus,
    input  core_mem_pkg::size_e size,
    input  logic [1:0]          addr_lo,   // Byte offset within the word
    output core_mem_pkg::word_t rdata
);

    import core_mem_pkg::*;

    always_comb begin
        case (size)
            SIZE_BYTE: begin
                rdata = {24'h0, rdata_bus[8*addr_lo +: 8]};
            end
            SIZE_HALFWORD: begin
                // addr_lo[0] is zero for aligned halfwords
                rdata = {16'h0, addr_lo[1] ? rdata_bus[31:16] : rdata_bus[15:0]};
            end
            default: begin
                rdata = rdata_bus;  // Full word
            end
        endcase
    end

endmodule

//--- access_decode.sv
// Access decode
// Aligns the address, builds byte strobes and replicates store data
`timescale 1ns/1ps

module access_decode (
    input  core_mem_pkg::limp_req_t sel_req,
    output core_mem_pkg::access_t   acc
);

    import core_mem_pkg::*;

    always_comb begin
        acc.wen_nren = sel_req.wen_nren;
        acc.addr     = {sel_req.addr[$bits(paddr_t)-1:2], 2'b00};  // Word aligned on the bus

        case (sel_req.size)
            SIZE_BYTE: begin
                acc.wstrb = 4'b0001 << sel_req.addr[1:0];  // One-hot lane
                acc.wdata = {4{sel_req.wdata[7:0]}};        // Byte lands in every lane
            end
            SIZE_HALFWORD: begin
                acc.wstrb = sel_req.addr[1] ? 4'b1100 : 4'b0011;
                acc.wdata = {2{sel_req.wdata[15:0]}};
            end
            SIZE_WORD: begin
                acc.wstrb = 4'b1111;
                acc.wdata = sel_req.wdata;
            end
            default: begin
                // Unused encoding, write nothing
                acc.wstrb = 4'b0000;
                acc.wdata = sel_req.wdata;
            end
        endcase
    end

    // Requestors only issue naturally aligned accesses
    always_comb begin
        if (!$isunknown(sel_req)) begin
            a_natural_align: assert (
                !(sel_req.size == SIZE_HALFWORD && sel_req.addr[0]) &&
                !(sel_req.size == SIZE_WORD && sel_req.addr[1:0] != 2'b00))
                else $error("access_decode: misaligned access size %0d addr %h",
                            sel_req.size, sel_req.addr);
        end
    end

endmodule

//--- limp_arbiter.sv
// Fixed-priority requestor arbiter
// Lowest index wins, and the grant is held until the transfer completes
`timescale 1ns/1ps
`include "mem_defs.svh"

module limp_arbiter #(
    parameter int NUM_REQUESTORS = `MEM_NUM_REQ
) (
    input  logic                                        i_clk,
    input  logic                                        i_rst_n,
    input  logic [NUM_REQUESTORS-1:0]                   req_valid,
    input  core_mem_pkg::limp_req_t [NUM_REQUESTORS-1:0] req,
    output logic [NUM_REQUESTORS-1:0]                   req_ready,
    input  logic                                        done,       // Completion from the FSM
    output logic                                        sel_valid,
    output core_mem_pkg::limp_req_t                     sel_req
);

    // Keep a one-bit index when there is only one requestor
    localparam int IDX_W = (NUM_REQUESTORS > 1) ? $clog2(NUM_REQUESTORS) : 1;

    logic             locked;    // Transfer in progress for lock_idx
    logic [IDX_W-1:0] lock_idx;
    logic [IDX_W-1:0] prio_idx;  // Winner if the bus were free
    logic [IDX_W-1:0] sel_idx;

    // Priority encoder, scan downwards so index 0 wins last
    always_comb begin
        prio_idx = '0;
        for (int i = NUM_REQUESTORS - 1; i >= 0; i--) begin
            if (req_valid[i]) begin
                prio_idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        sel_idx   = locked ? lock_idx : prio_idx;
        sel_valid = locked ? req_valid[sel_idx] : |req_valid;
        sel_req   = req[sel_idx];  // Request mux

        // Completion goes back only to the granted requestor
        req_ready          = '0;
        req_ready[sel_idx] = done;
    end

    // Lock once a transfer starts and does not finish in the same cycle
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            locked <= 1'b0;
        end else if (done) begin
            locked <= 1'b0;  // Bus free again next cycle
        end else if (!locked && sel_valid) begin
            locked <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!locked && sel_valid && !done) begin
            lock_idx <= prio_idx;
        end
    end

    // A granted requestor must keep its request up until it is served
    a_lock_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        locked |-> req_valid[lock_idx])
        else $error("limp_arbiter: requestor %0d dropped valid while granted", lock_idx);

endmodule

//--- axi_lite_pkg.sv
// AXI4-Lite channel payloads
// Address, data and response structs for a single-beat 32-bit bus
`include "mem_defs.svh"

package axi_lite_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // Read address channel
    typedef struct packed {
        logic [`MEM_PADDR_W-1:0]  addr;
        logic [`MEM_AXI_ID_W-1:0] id;
    } axi_ar_t;

    // Write address channel, same layout as AR
    typedef struct packed {
        logic [`MEM_PADDR_W-1:0]  addr;
        logic [`MEM_AXI_ID_W-1:0] id;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;  // Byte lane enables
    } axi_w_t;

    // Read data channel
    typedef struct packed {
        logic [31:0]              data;
        logic [`MEM_AXI_ID_W-1:0] id;
        axi_resp_e                resp;
    } axi_r_t;

    // Write response, status is not acted on
    typedef struct packed {
        logic [`MEM_AXI_ID_W-1:0] id;
        axi_resp_e                resp;
    } axi_b_t;

endpackage

//--- core_mem_pkg.sv
// Core-side memory request types
// Access size, the raw requestor request and the decoded bus access
`include "mem_defs.svh"

package core_mem_pkg;

    // Encoding follows the RISC-V funct3 low bits
    typedef enum logic [1:0] {
        SIZE_BYTE     = 2'b00,
        SIZE_HALFWORD = 2'b01,
        SIZE_WORD     = 2'b10
    } size_e;

    typedef logic [31:0] word_t;  // Data path is fixed at 32 bits
    typedef logic [`MEM_PADDR_W-1:0] paddr_t;

    // Request as raised by a requestor, unaligned sub-word form
    typedef struct packed {
        logic   wen_nren;  // 1 for store, 0 for load
        size_e  size;
        paddr_t addr;      // Byte address
        word_t  wdata;     // Store data in the low lanes
    } limp_req_t;

    // Request after lane decode, ready for the bus
    typedef struct packed {
        logic       wen_nren;
        paddr_t     addr;   // Word aligned
        logic [3:0] wstrb;  // One bit per byte lane
        word_t      wdata;  // Replicated across lanes
    } access_t;

endpackage

//--- mem_defs.svh
// Memory port build parameters
// Requestor count, physical address width and the fixed AXI ID
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// MMU, caches and uncached access
`define MEM_NUM_REQ 3

// Physical address width in bits
`define MEM_PADDR_W 32

`define MEM_AXI_ID_W 4  // Width of every AXI ID field

// Single ID on every channel, since only one transfer is ever in flight
`define MEM_AXI_ID 0

`endif
